// ==== build.f ====
+incdir+.
cache_pkg.sv
cache_req_decode.sv
cache_tlb.sv
cache_miss_engine.sv
cache_data_store.sv
cache_top.sv
tb_clock_gen.sv
cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module cache_tb \
  -Mdir obj_dir -o Vcache_tb -f build.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vcache_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// ==== cache_tb.sv ====
// testbench for cache_top, inputs change on falling edges only
// addresses come from a small pool so that hits and conflicts occur
// vmem accesses start only after every pool TLB index has an entry
// the memory model acks 1 to 4 cycles after mem_do_act, grant is random
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

  localparam int N_RAND     = 300;
  localparam int N_REQ      = N_RAND + 20;
  localparam int TIMEOUT_NS = N_REQ * 40 * 4;

  logic        CPU_CLK, RST;
  logic [31:0] precycle_addr, datao, datai, mem_addr, mem_dataintomem, mem_datafrommem;
  logic        precycle_enable, cycle_we, cachebusy_n, dma_mcu_access, mem_we;
  logic        mem_do_act, mem_ack, vmem_act, cache_inhibit, tlb_write_busy;
  logic        mmu_fault, we_tlb;

  integer seed     = 54777;
  integer mem_seed = 54777 + 1;
  int     err_cnt  = 0;
  int     wait_cnt = 0;
  bit     pending  = 1'b0;

  // external memory and its shadow copy
  logic [31:0] mem_model  [logic [31:0]];
  logic [31:0] shadow_mem [logic [31:0]];
  // shadow TLB and cache, one tag per word
  logic [13:0] s_ptag [256];
  logic [13:0] s_chk  [256];
  logic [31:0] s_data [256];
  logic [21:0] s_tag  [256];
  bit          s_valid[256];

  // bus transfers seen since the last check
  logic        bus_we_q[$];
  logic [31:0] bus_addr_q[$];
  logic [31:0] bus_data_q[$];

  logic [31:0] exp_data, exp_a0, exp_a1, exp_wd, obs_data;
  logic        exp_fault, exp_hit, exp_we, exp_busy_n, exp_rd, exp_tlb;
  logic        obs_busy_n, obs_fault, obs_tbusy;
  int          exp_nmem;
  event        access_done;

  tb_clock_gen #(.PERIOD(4.0), .RESET_CYCLES(4)) u_clk (.CPU_CLK(CPU_CLK), .RST(RST));

  cache_top uut (.*);

  task automatic stop_with_error(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic int unsigned urand(input int unsigned lim);
    return $unsigned($random(seed)) % lim;
  endfunction

  // memory contents before any write, every address bit counts
  function automatic logic [31:0] fill_pattern(input logic [31:0] wa);
    return {wa[15:0] ^ 16'h3c5a, wa[29:16] ^ 14'h1234, 2'b01};
  endfunction

  function automatic logic [31:0] shadow_read(input logic [31:0] wa);
    return shadow_mem.exists(wa) ? shadow_mem[wa] : fill_pattern(wa);
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic void ref_access(
    input  logic is_we, input logic is_tlb, input logic [31:0] addr,
    input  logic [31:0] data, input logic vmem, input logic inh,
    output logic [31:0] e_data, output logic e_fault, output logic e_hit,
    output int e_nmem, output logic e_we, output logic [31:0] e_a0,
    output logic [31:0] e_a1);
    logic [13:0] vtag, ptag;
    logic [7:0]  tidx, cidx, li;
    logic [31:0] wa;
    vtag = addr[31:18];
    tidx = addr[17:10];
    cidx = addr[9:2];
    {e_data, e_fault, e_hit, e_we, e_a0, e_a1} = '0;
    e_nmem = 0;
    // entry word goes to its own address, cache untouched
    if (is_tlb)
    begin
      e_nmem = 1;
      e_we   = 1'b1;
      e_a0   = {2'b00, addr[31:2]};
      shadow_mem[e_a0] = data;
      s_ptag[tidx] = data[29:16];
      s_chk[tidx]  = data[13:0];
      return;
    end
    if (inh)
      return;
    ptag    = vmem ? s_ptag[tidx] : vtag;
    e_fault = vmem && (s_chk[tidx] != vtag);
    if (e_fault)
      return;
    e_hit = s_valid[cidx] && (s_tag[cidx] == {ptag, tidx});
    wa    = {2'b00, ptag, tidx, cidx};
    if (is_we)
    begin
      e_nmem = 1;
      e_we   = 1'b1;
      e_a0   = wa;
      shadow_mem[wa] = data;
      s_data[cidx]   = data;
      s_tag[cidx]    = {ptag, tidx};
      s_valid[cidx]  = 1'b1;
    end
    else if (!e_hit)
    begin
      // two-word line fill, word 0 first
      e_nmem = 2;
      e_a0   = {wa[31:1], 1'b0};
      e_a1   = {wa[31:1], 1'b1};
      for (int w = 0; w < 2; w++)
      begin
        li = {cidx[7:1], w[0]};
        s_data[li]  = shadow_read({wa[31:1], w[0]});
        s_tag[li]   = {ptag, tidx};
        s_valid[li] = 1'b1;
      end
    end
    e_data = s_data[cidx];
  endfunction

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic run_access(input logic is_we, input logic is_tlb, input logic [31:0] addr,
                            input logic [31:0] data, input logic vmem, input logic inh);
    @(negedge CPU_CLK);
    ref_access(is_we, is_tlb, addr, data, vmem, inh, exp_data, exp_fault, exp_hit,
               exp_nmem, exp_we, exp_a0, exp_a1);
    exp_wd     = data;
    exp_tlb    = is_tlb;
    exp_rd     = !is_we && !is_tlb && !inh && !exp_fault;
    exp_busy_n = is_tlb || inh || exp_fault || (!is_we && exp_hit);
    precycle_addr = addr;
    datao         = data;
    vmem_act      = vmem;
    cache_inhibit = inh;
    we_tlb        = is_tlb;
    precycle_enable = !is_tlb;
    cycle_we        = is_we && !is_tlb;
    // request cycle, inhibit stays up until the next access sets it
    @(negedge CPU_CLK);
    obs_busy_n = cachebusy_n;
    obs_fault  = mmu_fault;
    obs_tbusy  = tlb_write_busy;
    precycle_enable = 1'b0;
    we_tlb          = 1'b0;
    while (is_tlb ? tlb_write_busy : !cachebusy_n)
      @(negedge CPU_CLK);
    obs_data = datai;
    cycle_we = 1'b0;
    -> access_done;
  endtask

  function automatic logic [31:0] pick_addr();
    return {14'(urand(3)), 8'(urand(4) * 85), 8'(urand(16)), 2'b00};
  endfunction

  // ----------------------------------------
  // checker
  // ----------------------------------------
  initial
  begin
    forever
    begin
      @(access_done);
      assert (obs_busy_n == exp_busy_n)
      else stop_with_error($sformatf(
        "mismatch at %0t: cachebusy_n %b in request cycle, expected %b",
        $time, obs_busy_n, exp_busy_n));
      assert (obs_fault == exp_fault)
      else stop_with_error($sformatf("mismatch at %0t: mmu_fault %b, expected %b",
                                     $time, obs_fault, exp_fault));
      assert (!exp_tlb || obs_tbusy)
      else stop_with_error($sformatf("mismatch at %0t: tlb_write_busy low after we_tlb", $time));
      assert (!exp_rd || obs_data == exp_data)
      else stop_with_error($sformatf("mismatch at %0t: datai %h, expected %h",
                                     $time, obs_data, exp_data));
      assert (bus_addr_q.size() == exp_nmem)
      else stop_with_error($sformatf("mismatch at %0t: %0d memory transfers, expected %0d",
                                     $time, bus_addr_q.size(), exp_nmem));
      for (int i = 0; i < exp_nmem; i++)
      begin
        assert (bus_we_q[i] == exp_we && bus_addr_q[i] == ((i == 0) ? exp_a0 : exp_a1))
        else stop_with_error($sformatf("mismatch at %0t: transfer %0d we %b addr %h",
                                       $time, i, bus_we_q[i], bus_addr_q[i]));
        assert (!exp_we || bus_data_q[i] == exp_wd)
        else stop_with_error($sformatf("mismatch at %0t: write data %h, expected %h",
                                       $time, bus_data_q[i], exp_wd));
      end
      bus_we_q.delete();
      bus_addr_q.delete();
      bus_data_q.delete();
    end
  end

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial
  begin
    dma_mcu_access  = 1'b0;
    mem_ack         = 1'b0;
    mem_datafrommem = '0;
    forever
    begin
      @(negedge CPU_CLK);
      if (mem_ack)
        mem_ack = 1'b0;
      else if (mem_do_act)
      begin
        if (!pending)
        begin
          pending  = 1'b1;
          wait_cnt = $unsigned($random(mem_seed)) % 4;
        end
        if (wait_cnt == 0)
        begin
          // ack lands on the next rising edge while mem_do_act holds
          pending = 1'b0;
          mem_ack = 1'b1;
          mem_datafrommem = mem_model.exists(mem_addr) ? mem_model[mem_addr]
                                                        : fill_pattern(mem_addr);
          if (mem_we)
            mem_model[mem_addr] = mem_dataintomem;
          bus_we_q.push_back(mem_we);
          bus_addr_q.push_back(mem_addr);
          bus_data_q.push_back(mem_dataintomem);
        end
        else
          wait_cnt--;
      end
      else
        dma_mcu_access = ($unsigned($random(mem_seed)) % 4) != 0;
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    stop_with_error("timeout: the cache did not finish its accesses in time");
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    logic [31:0] a;
    int unsigned r;
    logic        vm;
    precycle_addr = '0;
    precycle_enable = 1'b0;
    datao = '0;
    cycle_we = 1'b0;
    vmem_act = 1'b0;
    cache_inhibit = 1'b0;
    we_tlb = 1'b0;
    @(posedge RST);
    @(negedge CPU_CLK);
    assert (cachebusy_n && !mem_do_act && !mem_we && !tlb_write_busy && !mmu_fault)
    else stop_with_error("outputs are not in their reset state after reset");
    // miss, hit, line partner hit
    a = 32'h0004_5418;
    run_access(0, 0, a, 0, 0, 0);
    run_access(0, 0, a, 0, 0, 0);
    run_access(0, 0, a ^ 32'h4, 0, 0, 0);
    // write-through then read back
    run_access(1, 0, 32'h0008_0024, 32'hcafe_0001, 0, 0);
    run_access(0, 0, 32'h0008_0024, 0, 0, 0);
    // TLB entries for every pool index
    for (int i = 0; i < 4; i++)
      run_access(0, 1, {14'(i), 8'(i * 85), 10'h040},
                 {2'b00, 14'(i + 1), 2'b00, 14'(i % 3)}, 0, 0);
    run_access(0, 0, {14'd1, 8'd85, 10'h010}, 0, 1, 0);
    run_access(0, 0, {14'd2, 8'd85, 10'h010}, 0, 1, 0);
    // inhibit leaves the cache alone
    run_access(0, 0, a, 0, 0, 1);
    run_access(1, 0, a, 32'h1111_2222, 0, 1);
    run_access(0, 0, a, 0, 0, 0);
    for (int n = 0; n < N_RAND; n++)
    begin
      r  = urand(16);
      a  = pick_addr();
      vm = (urand(4) == 0);
      if (r < 9)
        run_access(0, 0, a, 0, vm, 0);
      else if (r < 12)
        run_access(1, 0, a, $random(seed), vm, 0);
      else if (r < 14)
        run_access(r[0], 0, a, $random(seed), vm, 1);
      else
        run_access(0, 1, a, {2'b00, 14'(urand(4)), 2'b00, 14'(urand(3))}, 0, 0);
    end
    repeat (4) @(negedge CPU_CLK);
    if (err_cnt == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// clock and reset source for the cache testbench
// reset is active low and released on a falling edge
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD       = 4.0,
  parameter int  RESET_CYCLES = 4
) (
  output logic CPU_CLK,
  output logic RST
);

  initial
  begin
    CPU_CLK = 1'b0;
    forever
      #(PERIOD / 2.0) CPU_CLK = ~CPU_CLK;
  end

  // held low for RESET_CYCLES rising edges
  initial
  begin
    RST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CPU_CLK);
    @(negedge CPU_CLK);
    RST = 1'b1;
  end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
// direct-mapped write-through cache with a direct-mapped TLB in front
// single clock, the CPU gives the next address one cycle early
// the CPU never drives we_tlb together with cycle_we
// vmem_act is sampled with precycle_enable
`timescale 1ns/10ps
`default_nettype none

module cache_top (
  input  wire        CPU_CLK,
  input  wire        RST,
  input  wire [31:0] precycle_addr,
  input  wire        precycle_enable,
  input  wire [31:0] datao,
  output logic [31:0] datai,
  input  wire        cycle_we,
  output logic       cachebusy_n,
  input  wire        dma_mcu_access,
  output logic [31:0] mem_addr,
  output logic       mem_we,
  output logic       mem_do_act,
  output logic [31:0] mem_dataintomem,
  input  wire        mem_ack,
  input  wire [31:0] mem_datafrommem,
  input  wire        vmem_act,
  input  wire        cache_inhibit,
  output logic       tlb_write_busy,
  output logic       mmu_fault,
  input  wire        we_tlb
);

  import cache_pkg::*;

  cache_req_t req;
  tlb_rsp_t   rsp;
  mem_req_t   mreq;
  logic       hit;
  logic       busy;
  logic       ctag_valid;
  logic [21:0] ctag;

  // decode
  cache_req_decode u_decode (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .precycle_addr   (precycle_addr),
    .precycle_enable (precycle_enable),
    .cycle_we        (cycle_we),
    .datao           (datao),
    .we_tlb          (we_tlb),
    .vmem_act        (vmem_act),
    .busy            (busy),
    .req             (req)
  );

  // translation
  cache_tlb u_tlb (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .precycle_addr   (precycle_addr),
    .precycle_enable (precycle_enable),
    .req             (req),
    .rsp             (rsp)
  );

  // execute
  cache_miss_engine u_engine (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .req             (req),
    .rsp             (rsp),
    .ctag_valid      (ctag_valid),
    .ctag            (ctag),
    .cache_inhibit   (cache_inhibit),
    .dma_mcu_access  (dma_mcu_access),
    .mem_ack         (mem_ack),
    .cachebusy_n     (cachebusy_n),
    .mmu_fault       (mmu_fault),
    .hit             (hit),
    .busy            (busy),
    .tlb_write_busy  (tlb_write_busy),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .mreq            (mreq)
  );

  // result
  cache_data_store u_store (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .precycle_addr   (precycle_addr),
    .precycle_enable (precycle_enable),
    .req             (req),
    .mreq            (mreq),
    .hit             (hit),
    .ptag            (rsp.ptag),
    .mem_datafrommem (mem_datafrommem),
    .datai           (datai),
    .ctag_valid      (ctag_valid),
    .ctag            (ctag)
  );

endmodule

`default_nettype wire

// ==== cache_data_store.sv ====
// result stage with the data array, the tag array and the valid bits
// all arrays are read on precycle_enable with address bits 9..2
// tags are kept per word, so a single store can allocate its word
// only the valid bits are cleared by reset
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_data_store (
  input  wire                        CPU_CLK,
  input  wire                        RST,
  input  wire [31:0]                 precycle_addr,
  input  wire                        precycle_enable,
  input  wire cache_pkg::cache_req_t req,
  input  wire cache_pkg::mem_req_t   mreq,
  input  wire                        hit,
  input  wire [`VTAG_W-1:0]          ptag,
  input  wire [31:0]                 mem_datafrommem,
  output logic [31:0]                datai,
  output logic                       ctag_valid,
  output logic [`CTAG_W-1:0]         ctag
);

  logic [31:0]             data_mem [`CACHE_DEPTH];
  logic [`CTAG_W-1:0]      tag_mem  [`CACHE_DEPTH];
  logic [`CACHE_DEPTH-1:0] valid_vec;

  logic [`CACHE_IDX_W-1:0] rd_idx;
  logic [`CACHE_IDX_W-1:0] wr_idx;
  logic [31:0]             wr_data;
  logic [`CTAG_W-1:0]      wr_tag;
  logic                    wr_en;
  logic [31:0]             rd_data;
  // requested word caught during the refill
  logic [31:0]             fill_q;

  assign rd_idx = precycle_addr[`CACHE_IDX_LSB +: `CACHE_IDX_W];

  // ----------------------------------------
  // write port, refill or store
  // ----------------------------------------
  assign wr_en   = mreq.fill_we || mreq.cpu_we;
  assign wr_idx  = mreq.cpu_we ? req.cache_idx : mreq.fill_idx;
  assign wr_data = mreq.cpu_we ? req.wdata.data : mem_datafrommem;
  // both words of a line carry the same tag
  assign wr_tag  = {ptag, req.tlb_idx};

  always_ff @(posedge CPU_CLK)
  begin
    if (wr_en)
    begin
      data_mem[wr_idx] <= wr_data;
      tag_mem[wr_idx]  <= wr_tag;
    end
    // lookup one cycle ahead of the request cycle
    if (precycle_enable)
    begin
      rd_data <= data_mem[rd_idx];
      ctag    <= tag_mem[rd_idx];
    end
    if (mreq.fill_we && mreq.fill_word)
      fill_q <= mem_datafrommem;
  end

  // valid bits
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid_vec  <= '0;
      ctag_valid <= 1'b0;
    end
    else
    begin
      if (wr_en)
        valid_vec[wr_idx] <= 1'b1;
      if (precycle_enable)
        ctag_valid <= valid_vec[rd_idx];
    end
  end

  // ----------------------------------------
  // read data select
  // ----------------------------------------

  // array word on a hit, refill word at the end of a miss
  assign datai = hit ? rd_data : fill_q;

endmodule

`default_nettype wire

// ==== cache_miss_engine.sv ====
// execute stage, hit detect plus the FSM for misses and memory writes
// mem_do_act rises only with dma_mcu_access and then holds until mem_ack
// the CPU holds the request and gives no precycle_enable while busy
// a TLB write keeps cachebusy_n high and shows on tlb_write_busy instead
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_miss_engine (
  input  wire                        CPU_CLK,
  input  wire                        RST,
  input  wire cache_pkg::cache_req_t req,
  input  wire cache_pkg::tlb_rsp_t   rsp,
  input  wire                        ctag_valid,
  input  wire [`CTAG_W-1:0]          ctag,
  input  wire                        cache_inhibit,
  input  wire                        dma_mcu_access,
  input  wire                        mem_ack,
  output logic                       cachebusy_n,
  output logic                       mmu_fault,
  output logic                       hit,
  output logic                       busy,
  output logic                       tlb_write_busy,
  output logic [31:0]                mem_addr,
  output logic                       mem_we,
  output logic                       mem_do_act,
  output logic [31:0]                mem_dataintomem,
  output cache_pkg::mem_req_t        mreq
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FILL,
    ST_WRITE,
    ST_TLBW,
    ST_DONE
  } state_t;

  state_t              state_q;
  state_t              state_d;
  logic                fill_cnt_q;
  logic                act_q;
  logic [31:0]         wdata_q;
  logic                start;
  logic                mem_state;
  logic                ack_ok;
  logic                fill_last;
  logic [`VTAG_W-1:0]  tag_sel;
  logic                word_bit;

  // ----------------------------------------
  // request cycle decisions
  // ----------------------------------------

  // stored tag is physical tag plus TLB index
  assign hit = ctag_valid && (ctag == {rsp.ptag, req.tlb_idx});

  // inhibit and fault both finish the access at once
  assign start     = (state_q == ST_IDLE) && req.valid && !cache_inhibit && !rsp.fault;
  assign mmu_fault = (state_q == ST_IDLE) && req.valid && !cache_inhibit && rsp.fault;

  assign mem_state = (state_q == ST_FILL) || (state_q == ST_WRITE) || (state_q == ST_TLBW);
  assign busy      = mem_state;

  // low for a miss or a store from the request cycle on
  assign cachebusy_n = !((state_q == ST_FILL) || (state_q == ST_WRITE) ||
                         (start && (req.we || !hit)));

  // ----------------------------------------
  // memory bus
  // ----------------------------------------
  assign mem_do_act = mem_state && (dma_mcu_access || act_q);
  assign ack_ok     = mem_do_act && mem_ack;
  assign fill_last  = (fill_cnt_q == 1'(`LINE_WORDS - 1));

  // entry word goes to its untranslated address
  assign tag_sel  = (state_q == ST_TLBW) ? req.vtag : rsp.ptag;
  assign word_bit = (state_q == ST_FILL) ? fill_cnt_q : req.cache_idx[0];
  // word address, byte address shifted down by 2
  assign mem_addr = {2'b00, tag_sel, req.tlb_idx, req.cache_idx[`CACHE_IDX_W-1:1], word_bit};

  assign mem_we          = (state_q == ST_WRITE) || (state_q == ST_TLBW);
  assign mem_dataintomem = wdata_q;
  assign tlb_write_busy  = (state_q == ST_TLBW);

  // strobes for the data store on the ack edge
  always_comb
  begin
    mreq.fill_we   = (state_q == ST_FILL) && ack_ok;
    mreq.fill_idx  = {req.cache_idx[`CACHE_IDX_W-1:1], fill_cnt_q};
    mreq.fill_word = (fill_cnt_q == req.word_sel);
    mreq.cpu_we    = (state_q == ST_WRITE) && ack_ok;
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
      begin
        if (req.tlb_we)
          state_d = ST_TLBW;
        else if (start && req.we)
          state_d = ST_WRITE;
        else if (start && !hit)
          state_d = ST_FILL;
      end
      ST_FILL:
      begin
        if (ack_ok && fill_last)
          state_d = ST_DONE;
      end
      ST_WRITE:
      begin
        if (ack_ok)
          state_d = ST_DONE;
      end
      // no done cycle, the CPU never waited on cachebusy_n
      ST_TLBW:
      begin
        if (ack_ok)
          state_d = ST_IDLE;
      end
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state_q    <= ST_IDLE;
      fill_cnt_q <= 1'b0;
      act_q      <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // remember a started transfer so a grant drop cannot abort it
      if (ack_ok)
        act_q <= 1'b0;
      else if (mem_do_act)
        act_q <= 1'b1;
      // line word counter, first word is word 0
      if (state_q == ST_IDLE)
        fill_cnt_q <= 1'b0;
      else if (mreq.fill_we)
        fill_cnt_q <= fill_cnt_q + 1'b1;
    end
  end

  // entry word is only present in the we_tlb cycle
  always_ff @(posedge CPU_CLK)
  begin
    if ((state_q == ST_IDLE) && (req.tlb_we || (start && req.we)))
      wdata_q <= req.wdata.data;
  end

  // address, direction and data stay put until the ack
  a_act_held_to_ack: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    (mem_do_act && !mem_ack) |=> (mem_do_act && $stable(mem_addr) && $stable(mem_we) &&
                                  $stable(mem_dataintomem))
  );

  // a request arriving mid transfer would shift the held address
  a_no_req_while_busy: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    busy |-> !req.valid
  );

endmodule

`default_nettype wire

// ==== cache_tlb.sv ====
// direct-mapped TLB with 256 entries
// read on precycle_enable with address bits 17..10, one cycle like decode
// entries are not initialised, so software fills one before it is used
// with vmem off the virtual tag passes straight through
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_tlb (
  input  wire                    CPU_CLK,
  input  wire                    RST,
  input  wire [31:0]             precycle_addr,
  input  wire                    precycle_enable,
  input  wire cache_pkg::cache_req_t req,
  output cache_pkg::tlb_rsp_t    rsp
);

  // physical tags and check tags
  logic [`VTAG_W-1:0]    ptag_mem [`TLB_DEPTH];
  logic [`VTAG_W-1:0]    chk_mem  [`TLB_DEPTH];

  logic [`TLB_IDX_W-1:0] idx;
  logic [`VTAG_W-1:0]    ptag_q;
  logic [`VTAG_W-1:0]    chk_q;

  // same index for the write pulse and the lookup
  assign idx = precycle_addr[`TLB_IDX_LSB +: `TLB_IDX_W];

  // ----------------------------------------
  // entry arrays
  // ----------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    // entry view of the written word, low 14 bits of each half
    if (req.tlb_we)
    begin
      ptag_mem[idx] <= req.wdata.entry.ptag[`VTAG_W-1:0];
      chk_mem[idx]  <= req.wdata.entry.ctag[`VTAG_W-1:0];
    end
    // read old contents when a write hits the same entry
    if (precycle_enable)
    begin
      ptag_q <= ptag_mem[idx];
      chk_q  <= chk_mem[idx];
    end
  end

  // ----------------------------------------
  // translation
  // ----------------------------------------
  always_comb
  begin
    if (req.vmem)
    begin
      rsp.ptag  = ptag_q;
      // check tag must equal the virtual tag of the request
      rsp.fault = (chk_q != req.vtag);
    end
    else
    begin
      // identity mapping
      rsp.ptag  = req.vtag;
      rsp.fault = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== cache_req_decode.sv ====
// decode stage of the cache
// the address is taken on precycle_enable or on a we_tlb pulse
// cycle_we and datao are levels that the CPU holds while the cache is busy
// we_tlb and datao count in the cycle of the pulse only
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_req_decode (
  input  wire                    CPU_CLK,
  input  wire                    RST,
  input  wire [31:0]             precycle_addr,
  input  wire                    precycle_enable,
  input  wire                    cycle_we,
  input  wire [31:0]             datao,
  input  wire                    we_tlb,
  input  wire                    vmem_act,
  input  wire                    busy,
  output cache_pkg::cache_req_t  req
);

  // word address of the current request, byte offset dropped
  logic [31:2] addr_q;
  logic        vmem_q;
  logic        valid_q;

  // ----------------------------------------
  // request registers
  // ----------------------------------------

  // control flags
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      valid_q <= 1'b0;
      vmem_q  <= 1'b0;
    end
    else
    begin
      // one cycle pulse marks the request cycle
      valid_q <= precycle_enable;
      // vmem_act sampled together with the address
      if (precycle_enable)
        vmem_q <= vmem_act;
    end
  end

  // TLB writes also need the address for the entry word write
  always_ff @(posedge CPU_CLK)
  begin
    if (precycle_enable || we_tlb)
      addr_q <= precycle_addr[31:2];
  end

  // ----------------------------------------
  // field split
  // ----------------------------------------
  always_comb
  begin
    req.vtag       = addr_q[`VTAG_LSB +: `VTAG_W];
    req.tlb_idx    = addr_q[`TLB_IDX_LSB +: `TLB_IDX_W];
    req.cache_idx  = addr_q[`CACHE_IDX_LSB +: `CACHE_IDX_W];
    // word within the two-word line
    req.word_sel   = addr_q[`CACHE_IDX_LSB];
    // store flag only counts in the request cycle or while in flight
    req.we         = cycle_we && (valid_q || busy);
    // TLB write acts in the pulse cycle itself
    req.tlb_we     = we_tlb;
    req.wdata.data = datao;
    req.vmem       = vmem_q;
    req.valid      = valid_q;
  end

  // a store and a TLB write may not share a cycle
  a_no_tlb_and_store: assert property (
    @(posedge CPU_CLK) disable iff (!RST)
    we_tlb |-> !cycle_we
  );

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// shared request, translation and refill types for the cache
// field widths come from cache_config.svh
// a TLB entry uses only the low 14 bits of each 16-bit half
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

  // TLB entry as the CPU writes it
  typedef struct packed {
    logic [15:0] ptag;
    logic [15:0] ctag;
  } tlb_entry_t;

  // one CPU word, plain store data or a TLB entry
  typedef union packed {
    logic [31:0] data;
    tlb_entry_t  entry;
  } cpu_word_u;

  // registered request as seen in the request cycle
  typedef struct packed {
    logic [`VTAG_W-1:0]      vtag;
    logic [`TLB_IDX_W-1:0]   tlb_idx;
    logic [`CACHE_IDX_W-1:0] cache_idx;
    logic                    word_sel;
    logic                    we;
    logic                    tlb_we;
    cpu_word_u               wdata;
    logic                    vmem;
    logic                    valid;
  } cache_req_t;

  // translation result
  typedef struct packed {
    logic [`VTAG_W-1:0] ptag;
    logic               fault;
  } tlb_rsp_t;

  // refill and store strobes toward the data store
  typedef struct packed {
    logic                    fill_we;
    logic [`CACHE_IDX_W-1:0] fill_idx;
    logic                    fill_word;
    logic                    cpu_we;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== cache_config.svh ====
// array sizes and address field positions for the cache and the TLB
// the address split assumes 32-bit byte addresses and 32-bit words
// changing a width here also moves the field positions below
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache index from address bits 9..2
`define CACHE_IDX_W   8
`define CACHE_IDX_LSB 2
`define CACHE_DEPTH   (1 << `CACHE_IDX_W)

// TLB index from address bits 17..10
`define TLB_IDX_W     8
`define TLB_IDX_LSB   10
`define TLB_DEPTH     (1 << `TLB_IDX_W)

// virtual tag from bits 31..18, cache tag is physical tag plus TLB index
`define VTAG_W        14
`define VTAG_LSB      18
`define CTAG_W        22

// words fetched on a read miss
`define LINE_WORDS    2

`endif
